// File: bench/md_unit_properties.sv
module md_unit_properties (
   input logic clk,
   input logic reset,
   input logic req_valid,
   input logic req_ready,
   input logic resp_valid
);

   int unsigned fails = 0;   // failed assertion count

   // response is a single-cycle strobe
   a_single_strobe: assert property (
      @(posedge clk) disable iff (reset) resp_valid |=> !resp_valid
   ) else begin
      $error("resp_valid high for two cycles in a row");
      fails++;
   end

   a_busy_after_accept: assert property (
      @(posedge clk) disable iff (reset) (req_valid && req_ready) |=> !req_ready
   ) else begin
      $error("req_ready still high after acceptance");
      fails++;
   end

   // ready only comes back together with the response
   a_ready_with_resp: assert property (
      @(posedge clk) disable iff (reset) $rose(req_ready) |-> resp_valid
   ) else begin
      $error("req_ready rose without resp_valid");
      fails++;
   end

   a_reset_values: assert property (
      @(posedge clk) reset |=> (req_ready && !resp_valid)
   ) else begin
      $error("wrong req_ready or resp_valid after reset");
      fails++;
   end

endmodule

// File: bench/md_unit_tb.sv
`include "md_defines.svh"

module md_unit_tb;

   localparam int N_VEC   = 16;
   localparam int N_RAND  = 40;
   localparam int MUL_LAT = 7;
   localparam int DIV_LAT = 35;
   localparam int TIMEOUT = 60;

   // field codes for the table
   localparam logic MUL = 1'b0;
   localparam logic DIV = 1'b1;
   localparam logic U   = 1'b0;
   localparam logic S   = 1'b1;
   localparam logic LO  = 1'b0;
   localparam logic HI  = 1'b1;

   typedef struct packed {
      md_io_pkg::md_req_t  req;
      logic [`MD_XLEN-1:0] exp_res;
   } vec_t;

   logic                clk;
   logic                reset;
   logic                req_valid;
   md_io_pkg::md_req_t  req;
   logic                req_ready;
   logic                resp_valid;
   md_io_pkg::md_resp_t resp;
   vec_t                vectors [N_VEC];
   md_io_pkg::md_req_t  rnd_req;
   logic [31:0]         rnd;
   integer              seed;

   md_unit uut (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

   bind md_unit md_unit_properties u_props (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .resp_valid (resp_valid)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] want);
      if (got !== want) begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
         $display("Test FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic stop_on_timeout(input string what);
      $display("timed out at %0t while waiting for %s", $time, what);
      $display("Test FAILED");
      $fatal(1, "timeout");
   endtask

   function automatic logic [31:0] ref_result(input md_io_pkg::md_req_t r);
      logic        a_neg;
      logic        b_neg;
      logic        hi;
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] prod;
      logic [63:0] quo;
      logic [63:0] rm;
      a_neg = r.in_1_signed && r.in_1[31];
      b_neg = r.in_2_signed && r.in_2[31];
      hi    = (r.out_sel == md_io_pkg::MD_OUT_HI);
      a     = {{32{a_neg}}, r.in_1};
      b     = {{32{b_neg}}, r.in_2};
      if (r.op == md_io_pkg::MD_OP_MUL) begin
         prod = a * b;   // exact for every sign mix
         return hi ? prod[63:32] : prod[31:0];
      end
      if (b == 0) begin
         return hi ? r.in_1 : 32'hFFFFFFFF;
      end
      if (a_neg) a = -a;
      if (b_neg) b = -b;
      quo = a / b;
      rm  = a % b;
      if (a_neg ^ b_neg) quo = -quo;   // truncation toward zero
      if (a_neg) rm = -rm;
      return hi ? rm[31:0] : quo[31:0];
   endfunction

   // returns one cycle into the response, so requests go back to back
   task automatic apply_request(input md_io_pkg::md_req_t r, input logic [31:0] want);
      int n;
      int lat;
      n   = 0;
      lat = (r.op == md_io_pkg::MD_OP_MUL) ? MUL_LAT : DIV_LAT;
      while (!req_ready) begin
         n++;
         if (n > TIMEOUT) stop_on_timeout("req_ready");
         @(posedge clk);
         #2;
      end
      req_valid = 1'b1;
      req       = r;
      @(posedge clk);
      #2;
      req_valid = 1'b0;
      req       = '0;
      n         = 0;
      while (!resp_valid) begin
         check_value("req_ready while busy", req_ready, 0);
         n++;
         if (n > TIMEOUT) stop_on_timeout("resp_valid");
         @(posedge clk);
         #2;
      end
      check_value("edges from acceptance to resp_valid", n, lat);
      check_value("req_ready with resp_valid", req_ready, 1);
      check_value("result", resp.result, want);
   endtask

   initial begin
      seed      = 33082;
      reset     = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      // op, in_1_signed, in_2_signed, out_sel, in_1, in_2, expected
      vectors[0]  = {MUL, U, U, LO, 32'h00000003, 32'h00000005, 32'h0000000F};
      vectors[1]  = {MUL, S, S, LO, 32'hFFFFFFFF, 32'h00000007, 32'hFFFFFFF9};
      vectors[2]  = {MUL, S, S, HI, 32'hFFFFFFFF, 32'h00000007, 32'hFFFFFFFF};
      vectors[3]  = {MUL, U, U, HI, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFE};
      vectors[4]  = {MUL, S, S, HI, 32'h80000000, 32'h80000000, 32'h40000000};
      vectors[5]  = {MUL, S, S, LO, 32'h80000000, 32'hFFFFFFFF, 32'h80000000};
      vectors[6]  = {MUL, S, U, HI, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFFFFFF};
      vectors[7]  = {MUL, S, U, HI, 32'h7FFFFFFF, 32'h80000000, 32'h3FFFFFFF};
      vectors[8]  = {DIV, U, U, LO, 32'h00000064, 32'h00000007, 32'h0000000E};
      vectors[9]  = {DIV, U, U, HI, 32'h00000064, 32'h00000007, 32'h00000002};
      vectors[10] = {DIV, S, S, LO, 32'hFFFFFFF9, 32'h00000002, 32'hFFFFFFFD};
      vectors[11] = {DIV, S, S, HI, 32'hFFFFFFF9, 32'h00000002, 32'hFFFFFFFF};
      vectors[12] = {DIV, S, S, LO, 32'h80000000, 32'hFFFFFFFF, 32'h80000000};
      vectors[13] = {DIV, S, S, HI, 32'h80000000, 32'hFFFFFFFF, 32'h00000000};
      vectors[14] = {DIV, U, U, LO, 32'h12345678, 32'h00000000, 32'hFFFFFFFF};
      vectors[15] = {DIV, S, S, HI, 32'hFFFFFF00, 32'h00000000, 32'hFFFFFF00};
      repeat (16) @(posedge clk);
      #2;
      reset = 1'b0;
      check_value("req_ready after reset", req_ready, 1);
      check_value("resp_valid after reset", resp_valid, 0);
      for (int i = 0; i < N_VEC; i++) begin
         check_value("table entry vs model", ref_result(vectors[i].req), vectors[i].exp_res);
         apply_request(vectors[i].req, vectors[i].exp_res);
      end
      for (int i = 0; i < N_RAND; i++) begin
         rnd                 = $random(seed);
         rnd_req.op          = md_io_pkg::md_op_e'(rnd[0]);
         rnd_req.in_1_signed = rnd[1];
         rnd_req.in_2_signed = (rnd_req.op == DIV) ? rnd[1] : rnd[2];
         rnd_req.out_sel     = md_io_pkg::md_sel_e'(rnd[3]);
         rnd_req.in_1        = $random(seed);
         rnd_req.in_2        = $random(seed);
         if (rnd_req.op == DIV) rnd_req.in_2 = rnd_req.in_2 >> rnd[8:4];   // smaller divisors
         apply_request(rnd_req, ref_result(rnd_req));
      end
      if (uut.u_props.fails != 0) begin
         $display("%0d handshake assertion failures", uut.u_props.fails);
         $display("Test FAILED");
         $fatal(1, "assertion failures");
      end else begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

// File: flist.f
+incdir+include
logic/md_io_pkg.sv
logic/md_arith_pkg.sv
logic/md_ctrl.sv
logic/mul_seq.sv
logic/booth_recoder.sv
logic/mul_accum.sv
logic/div_iter.sv
logic/md_result.sv
logic/md_unit.sv
bench/md_unit_properties.sv
bench/md_unit_tb.sv

// File: include/md_defines.svh
`ifndef MD_DEFINES_SVH
`define MD_DEFINES_SVH

// operand width
`define MD_XLEN 32

// booth recoders working in parallel, two multiplier bits each
`define MD_BOOTH_PER_CYCLE 4

// 8 multiplier bits per iteration, 40 bits cover the 33-bit extended multiplier
`define MD_MUL_CYCLES 5

// one quotient bit per iteration
`define MD_DIV_CYCLES 32

`endif

// File: logic/booth_recoder.sv
`include "md_defines.svh"

module booth_recoder (
   input  logic [2:0]              booth_win,
   input  logic [`MD_XLEN+1:0]     mcand,
   output md_arith_pkg::booth_pp_t pp
);

   logic [`MD_XLEN+1:0] mcand_x2;

   assign mcand_x2 = {mcand[`MD_XLEN:0], 1'b0};

   // digit = -2*b2 + b1 + b0
   always_comb begin
      case (booth_win)
         3'b001, 3'b010: begin
            pp.pp  = mcand;
            pp.neg = 1'b0;
         end
         3'b011: begin
            pp.pp  = mcand_x2;
            pp.neg = 1'b0;
         end
         3'b100: begin
            pp.pp  = ~mcand_x2;   // -2m
            pp.neg = 1'b1;
         end
         3'b101, 3'b110: begin
            pp.pp  = ~mcand;      // -m
            pp.neg = 1'b1;
         end
         default: begin
            pp.pp  = '0;          // 000 and 111
            pp.neg = 1'b0;
         end
      endcase
   end

endmodule

// File: logic/div_iter.sv
`include "md_defines.svh"

module div_iter (
   input  logic                clk,
   input  logic                reset,
   input  logic                div_start,
   input  md_io_pkg::md_req_t  opnd,
   output logic [`MD_XLEN-1:0] quot,
   output logic [`MD_XLEN-1:0] rem,
   output logic                div_done
);

   localparam int CNT_W = $clog2(`MD_DIV_CYCLES + 1);

   logic [`MD_XLEN-1:0] dvd_q;      // dividend shifts out, quotient shifts in
   logic [`MD_XLEN-1:0] part_rem;
   logic [`MD_XLEN-1:0] dvs;
   logic [CNT_W-1:0]    cnt;
   logic                run;
   logic                fix;
   logic                neg_q;
   logic                neg_r;
   logic                dvs_zero;
   logic                a_neg;
   logic                b_neg;
   logic [`MD_XLEN:0]   shifted;
   logic [`MD_XLEN+1:0] trial;

   assign a_neg = opnd.in_1_signed & opnd.in_1[`MD_XLEN-1];
   assign b_neg = opnd.in_2_signed & opnd.in_2[`MD_XLEN-1];

   assign shifted = {part_rem, dvd_q[`MD_XLEN-1]};
   assign trial   = {1'b0, shifted} - {2'b00, dvs};   // msb set means borrow

   always_ff @(posedge clk) begin
      if (reset) begin
         run      <= 1'b0;
         fix      <= 1'b0;
         cnt      <= '0;
         div_done <= 1'b0;
      end else begin
         div_done <= fix;
         fix      <= run && (cnt == CNT_W'(1));
         if (div_start) begin
            run <= 1'b1;
            cnt <= CNT_W'(`MD_DIV_CYCLES);
         end else if (run) begin
            cnt <= cnt - 1'b1;
            if (cnt == CNT_W'(1)) begin
               run <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (div_start) begin
         dvd_q    <= a_neg ? -opnd.in_1 : opnd.in_1;   // magnitudes
         dvs      <= b_neg ? -opnd.in_2 : opnd.in_2;
         part_rem <= '0;
         neg_q    <= a_neg ^ b_neg;
         neg_r    <= a_neg;
         dvs_zero <= (opnd.in_2 == '0);
      end else if (run) begin
         if (!trial[`MD_XLEN+1]) begin
            part_rem <= trial[`MD_XLEN-1:0];
            dvd_q    <= {dvd_q[`MD_XLEN-2:0], 1'b1};
         end else begin
            part_rem <= shifted[`MD_XLEN-1:0];   // restore
            dvd_q    <= {dvd_q[`MD_XLEN-2:0], 1'b0};
         end
      end
   end

   // sign fix, zero divisor keeps the dividend as remainder
   always_ff @(posedge clk) begin
      if (fix) begin
         if (dvs_zero) begin
            quot <= '1;
         end else begin
            quot <= neg_q ? -dvd_q : dvd_q;
         end
         rem <= neg_r ? -part_rem : part_rem;
      end
   end

endmodule

// File: logic/md_arith_pkg.sv
`include "md_defines.svh"

package md_arith_pkg;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_MUL,
      ST_DIV
   } md_state_e;

   // one booth digit times the multiplicand
   // negative digits come as ones complement plus neg
   typedef struct packed {
      logic [`MD_XLEN+1:0] pp;
      logic                neg;
   } booth_pp_t;

endpackage

// File: logic/md_ctrl.sv
`include "md_defines.svh"

module md_ctrl (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req_valid,
   input  md_io_pkg::md_req_t   req,
   output logic                 req_ready,
   output logic                 mul_start,
   output logic                 div_start,
   output md_io_pkg::md_req_t   opnd,
   input  logic                 done
);

   md_arith_pkg::md_state_e state;
   logic                    start_q;
   logic                    accept;

   assign req_ready = (state == md_arith_pkg::ST_IDLE);
   assign accept    = req_valid && req_ready;

   // start strobe goes out the cycle after acceptance
   assign mul_start = start_q && (state == md_arith_pkg::ST_MUL);
   assign div_start = start_q && (state == md_arith_pkg::ST_DIV);

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= md_arith_pkg::ST_IDLE;
         start_q <= 1'b0;
      end else begin
         start_q <= accept;
         case (state)
            md_arith_pkg::ST_IDLE: begin
               if (accept) begin
                  if (req.op == md_io_pkg::MD_OP_MUL) begin
                     state <= md_arith_pkg::ST_MUL;
                  end else begin
                     state <= md_arith_pkg::ST_DIV;
                  end
               end
            end
            md_arith_pkg::ST_MUL,
            md_arith_pkg::ST_DIV: begin
               if (done) begin
                  state <= md_arith_pkg::ST_IDLE;   // ready again with resp_valid
               end
            end
            default: begin
               state <= md_arith_pkg::ST_IDLE;
            end
         endcase
      end
   end

   // operands and selects held for the whole operation
   always_ff @(posedge clk) begin
      if (accept) begin
         opnd <= req;
      end
   end

endmodule

// File: logic/md_io_pkg.sv
`include "md_defines.svh"

package md_io_pkg;

   typedef enum logic {
      MD_OP_MUL,
      MD_OP_DIV
   } md_op_e;

   // for divide, lo is the quotient and hi the remainder
   typedef enum logic {
      MD_OUT_LO,
      MD_OUT_HI
   } md_sel_e;

   typedef struct packed {
      md_op_e              op;
      logic                in_1_signed;
      logic                in_2_signed;
      md_sel_e             out_sel;
      logic [`MD_XLEN-1:0] in_1;   // multiplier / dividend
      logic [`MD_XLEN-1:0] in_2;   // multiplicand / divisor
   } md_req_t;

   typedef struct packed {
      logic [`MD_XLEN-1:0] result;
   } md_resp_t;

endpackage

// File: logic/md_result.sv
`include "md_defines.svh"

module md_result (
   input  logic                  clk,
   input  logic                  reset,
   input  md_io_pkg::md_req_t    opnd,
   input  logic [2*`MD_XLEN-1:0] product,
   input  logic                  mul_done,
   input  logic [`MD_XLEN-1:0]   quot,
   input  logic [`MD_XLEN-1:0]   rem,
   input  logic                  div_done,
   output logic                  resp_valid,
   output md_io_pkg::md_resp_t   resp
);

   logic [`MD_XLEN-1:0] word;

   always_comb begin
      if (opnd.op == md_io_pkg::MD_OP_MUL) begin
         if (opnd.out_sel == md_io_pkg::MD_OUT_HI) begin
            word = product[2*`MD_XLEN-1:`MD_XLEN];
         end else begin
            word = product[`MD_XLEN-1:0];
         end
      end else begin
         if (opnd.out_sel == md_io_pkg::MD_OUT_HI) begin
            word = rem;
         end else begin
            word = quot;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mul_done || div_done) begin
         resp.result <= word;
      end
   end

   // one-cycle strobe, no back-pressure
   always_ff @(posedge clk) begin
      if (reset) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= mul_done || div_done;
      end
   end

endmodule

// File: logic/md_unit.sv
`include "md_defines.svh"

module md_unit (
   input  logic                clk,
   input  logic                reset,
   input  logic                req_valid,
   input  md_io_pkg::md_req_t  req,
   output logic                req_ready,
   output logic                resp_valid,
   output md_io_pkg::md_resp_t resp
);

   md_io_pkg::md_req_t                               opnd;
   logic                                             mul_start;
   logic                                             div_start;
   logic                                             done;
   logic [`MD_XLEN+1:0]                              mcand;
   logic [`MD_BOOTH_PER_CYCLE-1:0][2:0]              booth_win;
   md_arith_pkg::booth_pp_t [`MD_BOOTH_PER_CYCLE-1:0] pps;
   logic                                             step;
   logic                                             mul_last;
   logic [2*`MD_XLEN-1:0]                            product;
   logic                                             mul_done;
   logic [`MD_XLEN-1:0]                              quot;
   logic [`MD_XLEN-1:0]                              rem;
   logic                                             div_done;

   assign done = mul_done | div_done;

   md_ctrl u_ctrl (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .mul_start (mul_start),
      .div_start (div_start),
      .opnd      (opnd),
      .done      (done)
   );

   mul_seq u_mul_seq (
      .clk       (clk),
      .reset     (reset),
      .mul_start (mul_start),
      .opnd      (opnd),
      .mcand     (mcand),
      .booth_win (booth_win),
      .step      (step),
      .mul_last  (mul_last)
   );

   for (genvar k = 0; k < `MD_BOOTH_PER_CYCLE; k++) begin : g_booth
      booth_recoder u_booth (
         .booth_win (booth_win[k]),
         .mcand     (mcand),
         .pp        (pps[k])
      );
   end

   mul_accum u_mul_accum (
      .clk      (clk),
      .reset    (reset),
      .step     (step),
      .mul_last (mul_last),
      .pps      (pps),
      .product  (product),
      .mul_done (mul_done)
   );

   div_iter u_div_iter (
      .clk       (clk),
      .reset     (reset),
      .div_start (div_start),
      .opnd      (opnd),
      .quot      (quot),
      .rem       (rem),
      .div_done  (div_done)
   );

   md_result u_result (
      .clk        (clk),
      .reset      (reset),
      .opnd       (opnd),
      .product    (product),
      .mul_done   (mul_done),
      .quot       (quot),
      .rem        (rem),
      .div_done   (div_done),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

endmodule

// File: logic/mul_accum.sv
`include "md_defines.svh"

module mul_accum (
   input  logic                                             clk,
   input  logic                                             reset,
   input  logic                                             step,
   input  logic                                             mul_last,
   input  md_arith_pkg::booth_pp_t [`MD_BOOTH_PER_CYCLE-1:0] pps,
   output logic [2*`MD_XLEN-1:0]                            product,
   output logic                                             mul_done
);

   localparam int SHIFT = 2 * `MD_BOOTH_PER_CYCLE;
   localparam int LO_W  = `MD_MUL_CYCLES * SHIFT;
   localparam int PP_W  = `MD_XLEN + 2;
   localparam int HI_W  = PP_W + SHIFT;   // room for four weighted pps plus carry

   logic [HI_W-1:0] hi;     // running sum above the bits already retired
   logic [LO_W-1:0] lo;     // retired low product bits
   logic [HI_W-1:0] sum;
   logic [HI_W-1:0] term;
   logic            first;

   assign product = {hi[2*`MD_XLEN-LO_W-1:0], lo};

   always_comb begin
      sum  = first ? '0 : hi;
      term = '0;
      for (int k = 0; k < `MD_BOOTH_PER_CYCLE; k++) begin
         term = {{(HI_W - PP_W){pps[k].pp[PP_W-1]}}, pps[k].pp};
         sum  = sum + (term << (2 * k)) + (HI_W'(pps[k].neg) << (2 * k));
      end
   end

   always_ff @(posedge clk) begin
      if (step) begin
         hi <= {{SHIFT{sum[HI_W-1]}}, sum[HI_W-1:SHIFT]};   // arithmetic shift
         lo <= {sum[SHIFT-1:0], lo[LO_W-1:SHIFT]};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         first    <= 1'b1;
         mul_done <= 1'b0;
      end else begin
         mul_done <= mul_last;
         if (step) begin
            first <= mul_last;   // next step starts a new product
         end
      end
   end

endmodule

// File: logic/mul_seq.sv
`include "md_defines.svh"

module mul_seq (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 mul_start,
   input  md_io_pkg::md_req_t                   opnd,
   output logic [`MD_XLEN+1:0]                  mcand,
   output logic [`MD_BOOTH_PER_CYCLE-1:0][2:0]  booth_win,
   output logic                                 step,
   output logic                                 mul_last
);

   localparam int SHIFT  = 2 * `MD_BOOTH_PER_CYCLE;
   localparam int MPLR_W = `MD_MUL_CYCLES * SHIFT + 1;
   localparam int CNT_W  = $clog2(`MD_MUL_CYCLES);

   logic [MPLR_W-1:0] mplr;   // extended multiplier with a zero below bit 0
   logic [CNT_W-1:0]  cnt;
   logic              busy;
   logic              a_ext;
   logic              b_ext;

   assign a_ext    = opnd.in_1_signed & opnd.in_1[`MD_XLEN-1];
   assign b_ext    = opnd.in_2_signed & opnd.in_2[`MD_XLEN-1];
   assign step     = busy;
   assign mul_last = busy && (cnt == CNT_W'(`MD_MUL_CYCLES - 1));

   // overlapping windows, digit k sits on bits 2k+1..2k-1
   always_comb begin
      for (int k = 0; k < `MD_BOOTH_PER_CYCLE; k++) begin
         booth_win[k] = mplr[2*k +: 3];
      end
   end

   always_ff @(posedge clk) begin
      if (mul_start) begin
         mplr  <= {{(MPLR_W - `MD_XLEN - 1){a_ext}}, opnd.in_1, 1'b0};
         mcand <= {{2{b_ext}}, opnd.in_2};
      end else if (busy) begin
         mplr  <= {{SHIFT{mplr[MPLR_W-1]}}, mplr[MPLR_W-1:SHIFT]};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (mul_start) begin
         busy <= 1'b1;
         cnt  <= '0;
      end else if (busy) begin
         cnt <= cnt + 1'b1;
         if (mul_last) begin
            busy <= 1'b0;
         end
      end
   end

endmodule
